// File: l2_cache.f
+incdir+.
l2_cache_pkg.sv
l2_sram.sv
l2_tag_match.sv
l2_plru.sv
l2_cache_fsm.sv
l2_cache_top.sv
l2_cache_checker.sv
tb_l2_cache.sv

// File: run.sh
#!/bin/sh
# build and run the l2 cache testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module tb_l2_cache \
    -f l2_cache.f -o tb_l2_cache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_l2_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# verdict comes from the log
if grep -q ">>> FAIL" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
exit 0

// File: tb_l2_cache.sv
`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module tb_l2_cache;

    import l2_cache_pkg::*;

    localparam int n_req        = 300;
    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam longint watchdog_ns = 64'(reset_cycles + n_req * 40) * clk_period;

    // two sets and six tags, so each set sees more tags than it has ways
    localparam logic [`L2_INDEX_W-1:0] set_pick [2] = '{9'h05a, 9'h1c3};
    localparam logic [`L2_TAG_W-1:0]   tag_pick [6] = '{17'h00001, 17'h1abcd, 17'h0f0f0,
                                                        17'h12345, 17'h00777, 17'h1ffff};

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  req;
    cpu_req_t              req_data;
    logic                  busy;
    logic                  rdy;
    logic [`L2_WORD_W-1:0] rdata;
    logic                  miss_stall;
    logic                  mem_req;
    mem_cmd_t              mem_cmd;
    logic                  mem_complete;
    logic [`L2_LINE_W-1:0] mem_rdata;
    logic                  all_done;
    int                    error_count;
    int                    req_count;
    logic [31:0]           lfsr;
    logic [5:0]            delays;   // writeback delay low, fill delay high
    logic [`L2_LINE_W-1:0] mem_lines [logic [`L2_MEM_ADDR_W-1:0]];   // written lines only

    always #(clk_period / 2) clk = ~clk;

    l2_cache_top dut (
        .clk(clk), .rst_n(rst_n), .req(req), .req_data(req_data),
        .busy(busy), .rdy(rdy), .rdata(rdata), .miss_stall(miss_stall),
        .mem_req(mem_req), .mem_cmd(mem_cmd),
        .mem_complete(mem_complete), .mem_rdata(mem_rdata)
    );

    l2_cache_checker chk (
        .clk(clk), .rst_n(rst_n), .req(req), .req_data(req_data),
        .busy(busy), .rdy(rdy), .rdata(rdata), .miss_stall(miss_stall),
        .mem_req(mem_req), .mem_cmd(mem_cmd), .all_done(all_done),
        .error_count(error_count), .req_count(req_count)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit handed out
    function automatic logic [127:0] draw(input int n);
        logic [127:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic [`L2_LINE_W-1:0] read_line(input logic [`L2_MEM_ADDR_W-1:0] a);
        logic [`L2_LINE_W-1:0] l;
        if (mem_lines.exists(a)) return mem_lines[a];
        for (int c = 0; c < 16; c++) begin
            l[c*32 +: 32] = {6'(c), a};   // chunk number above the line address
        end
        return l;
    endfunction

    task automatic issue_request();
        cpu_req_t r;
        r              = '0;
        r.write        = 1'(draw(1));
        r.addr.index   = set_pick[int'(draw(1))];
        r.addr.tag     = tag_pick[int'(draw(3)) % 6];
        r.addr.offset  = 2'(draw(2));
        r.wdata        = draw(128);
        delays        <= 6'(draw(6));
        req_data      <= r;
        req           <= 1'b1;
    endtask

    task automatic serve_memory();
        mem_cmd_t cmd;
        int       wait_cycles;
        cmd         = mem_cmd;
        wait_cycles = cmd.write ? int'(delays[2:0]) : int'(delays[5:3]);
        if (cmd.write) mem_lines[cmd.line_addr] = cmd.wline;
        repeat (wait_cycles) @(posedge clk);
        mem_complete <= 1'b1;
        mem_rdata    <= cmd.write ? '0 : read_line(cmd.line_addr);
        @(posedge clk);
        mem_complete <= 1'b0;
    endtask

    initial begin
        mem_complete = 1'b0;
        mem_rdata    = '0;
        forever begin
            @(posedge clk);
            if (rst_n && mem_req) serve_memory();
        end
    end

    initial begin
        lfsr     = 32'h13d7;
        rst_n    = 1'b0;
        req      = 1'b0;
        req_data = '0;
        all_done = 1'b0;
        delays   = 6'd0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;
        repeat (3) @(posedge clk);
        for (int i = 0; i < n_req; i++) begin
            while (busy) @(posedge clk);
            issue_request();
            @(posedge clk);
            req <= 1'b0;
            @(posedge clk);
        end
        while (busy) @(posedge clk);
        all_done <= 1'b1;
        repeat (3) @(posedge clk);
        if (req_count != n_req) begin
            $display("checker saw %0d of %0d requests", req_count, n_req);
        end
        if (error_count == 0 && req_count == n_req) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the cache stopped responding", watchdog_ns);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: l2_cache_checker.sv
`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module l2_cache_checker (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  l2_cache_pkg::cpu_req_t req_data,
    input  logic                   busy,
    input  logic                   rdy,
    input  logic [`L2_WORD_W-1:0]  rdata,
    input  logic                   miss_stall,
    input  logic                   mem_req,
    input  l2_cache_pkg::mem_cmd_t mem_cmd,
    input  logic                   all_done,
    output int                     error_count,
    output int                     req_count
);

    import l2_cache_pkg::*;

    logic                  m_valid [`L2_SETS][`L2_WAYS];
    logic                  m_dirty [`L2_SETS][`L2_WAYS];
    logic [`L2_TAG_W-1:0]  m_tag   [`L2_SETS][`L2_WAYS];
    logic [`L2_LINE_W-1:0] m_line  [`L2_SETS][`L2_WAYS];
    logic                  t_root  [`L2_SETS];
    logic                  t_left  [`L2_SETS];
    logic                  t_right [`L2_SETS];
    logic [`L2_WORD_W-1:0] mem_words [logic [`L2_MEM_ADDR_W+1:0]];   // keyed by word address
    int                    hits;
    int                    misses;
    int                    writebacks;
    bit                    reported;

    task automatic flag(input string msg);
        $display("[ERROR] t=%0t %s", $time, msg);
        error_count++;
    endtask

    function automatic logic [`L2_WORD_W-1:0] mem_word(input logic [`L2_MEM_ADDR_W-1:0] a,
                                                       input logic [1:0] w);
        logic [`L2_WORD_W-1:0] v;
        if (mem_words.exists({a, w})) return mem_words[{a, w}];
        for (int c = 0; c < 4; c++) begin
            v[c*32 +: 32] = {6'(4 * int'(w) + c), a};   // untouched memory pattern
        end
        return v;
    endfunction

    function automatic int find_way(input logic [`L2_INDEX_W-1:0] idx,
                                    input logic [`L2_TAG_W-1:0] tag);
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) return w;
        end
        return -1;
    endfunction

    function automatic int pick_victim(input logic [`L2_INDEX_W-1:0] idx);
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (!m_valid[idx][w]) return w;
        end
        if (!t_root[idx]) return t_left[idx] ? 1 : 0;
        return t_right[idx] ? 3 : 2;
    endfunction

    task automatic serve_request(input cpu_req_t r);
        logic [`L2_INDEX_W-1:0]    idx;
        logic [`L2_MEM_ADDR_W-1:0] line_addr;
        logic [`L2_MEM_ADDR_W-1:0] vic_addr;
        logic [`L2_MEM_ADDR_W-1:0] wr_addr;
        logic [`L2_MEM_ADDR_W-1:0] rd_addr;
        logic [`L2_LINE_W-1:0]     wr_line;
        int way, cycles, n_wr, n_rd, errs_before, pos;
        bit hit, wb, wr_late, stall_seen, stall_gap, busy_gap;
        idx         = r.addr.index;
        line_addr   = {r.addr.tag, idx};
        way         = find_way(idx, r.addr.tag);
        hit         = (way >= 0);
        wb          = 1'b0;
        cycles      = 0;
        n_wr        = 0;
        n_rd        = 0;
        wr_late     = 1'b0;
        stall_seen  = 1'b0;
        stall_gap   = 1'b0;
        busy_gap    = 1'b0;
        errs_before = error_count;
        pos         = int'(r.addr.offset) * `L2_WORD_W;
        req_count++;
        do begin
            @(posedge clk);
            cycles++;
            if (mem_req && mem_cmd.write) begin
                n_wr++;
                wr_addr = mem_cmd.line_addr;
                wr_line = mem_cmd.wline;
                wr_late = (n_rd > 0);
            end else if (mem_req) begin
                n_rd++;
                rd_addr = mem_cmd.line_addr;
            end
            if (!rdy && miss_stall) stall_seen = 1'b1;
            if (!rdy && !miss_stall) stall_gap = 1'b1;
            if (!rdy && !busy) busy_gap = 1'b1;
        end while (!rdy);
        if (miss_stall) flag("miss_stall still high when rdy arrives");
        if (busy) flag("busy still high when rdy arrives");
        if (busy_gap) flag("busy dropped before rdy");
        if (hit) begin
            hits++;
            if (cycles != 2) flag($sformatf("hit took %0d cycles to rdy, expected 2", cycles));
            if (stall_seen) flag("miss_stall raised on a hit");
            if (n_wr + n_rd != 0) flag("memory request issued on a hit");
        end else begin
            misses++;
            way      = pick_victim(idx);
            wb       = m_valid[idx][way] && m_dirty[idx][way];
            vic_addr = {m_tag[idx][way], idx};
            if (!stall_seen || stall_gap) flag("miss_stall not held high through the miss");
            if (wb) begin
                writebacks++;
                if (n_wr != 1 || wr_late) begin
                    flag($sformatf("expected one writeback before the fill, saw %0d", n_wr));
                end else if (wr_addr != vic_addr) begin
                    flag($sformatf("writeback to %07h, expected %07h", wr_addr, vic_addr));
                end else if (wr_line != m_line[idx][way]) begin
                    flag($sformatf("writeback data for %07h differs from the model", wr_addr));
                end
                for (int w = 0; w < 4; w++) begin
                    mem_words[{vic_addr, 2'(w)}] = m_line[idx][way][w*`L2_WORD_W +: `L2_WORD_W];
                end
            end else if (n_wr != 0) begin
                flag("memory write issued for a clean or empty victim");
            end
            if (n_rd != 1) begin
                flag($sformatf("expected one fill read, saw %0d", n_rd));
            end else if (rd_addr != line_addr) begin
                flag($sformatf("fill read from %07h, expected %07h", rd_addr, line_addr));
            end
            for (int w = 0; w < 4; w++) begin
                m_line[idx][way][w*`L2_WORD_W +: `L2_WORD_W] = mem_word(line_addr, 2'(w));
            end
            m_valid[idx][way] = 1'b1;
            m_dirty[idx][way] = 1'b0;
            m_tag[idx][way]   = r.addr.tag;
        end
        // tree points away from the way just used
        t_root[idx] = (way < 2);
        if (way < 2) t_left[idx] = (way == 0);
        else t_right[idx] = (way == 2);
        if (r.write) begin
            m_line[idx][way][pos +: `L2_WORD_W] = r.wdata;
            m_dirty[idx][way] = 1'b1;
        end else if (rdata !== m_line[idx][way][pos +: `L2_WORD_W]) begin
            flag($sformatf("read of %08h returned %032h, expected %032h", r.addr, rdata,
                           m_line[idx][way][pos +: `L2_WORD_W]));
        end
        $display("req %0d: %s set %03h tag %05h off %0d, %s%s, %s", req_count,
                 r.write ? "wr" : "rd", idx, r.addr.tag, r.addr.offset,
                 hit ? "hit" : "miss", wb ? " wb" : "",
                 (error_count == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        error_count = 0;
        req_count   = 0;
        hits        = 0;
        misses      = 0;
        writebacks  = 0;
        reported    = 1'b0;
        for (int s = 0; s < `L2_SETS; s++) begin
            t_root[s]  = 1'b0;
            t_left[s]  = 1'b0;
            t_right[s] = 1'b0;
            for (int w = 0; w < `L2_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
        forever begin
            @(posedge clk);
            if (rst_n) begin
                if (busy || rdy || miss_stall || mem_req) begin
                    flag($sformatf("outputs not idle: busy %0b rdy %0b stall %0b mem_req %0b",
                                   busy, rdy, miss_stall, mem_req));
                end
                if (req) begin
                    serve_request(req_data);
                end else if (all_done && !reported) begin
                    reported = 1'b1;
                    $display("requests %0d, hits %0d, misses %0d, writebacks %0d, errors %0d",
                             req_count, hits, misses, writebacks, error_count);
                end
            end
        end
    end

endmodule

// File: l2_cache_top.sv
`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module l2_cache_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req,
    input  l2_cache_pkg::cpu_req_t req_data,
    output logic                   busy,
    output logic                   rdy,
    output logic [`L2_WORD_W-1:0]  rdata,
    output logic                   miss_stall,
    output logic                   mem_req,
    output l2_cache_pkg::mem_cmd_t mem_cmd,
    input  logic                   mem_complete,
    input  logic [`L2_LINE_W-1:0]  mem_rdata
);

    import l2_cache_pkg::*;

    tag_entry_t [`L2_WAYS-1:0]           tags;
    logic [`L2_WAYS-1:0][`L2_LINE_W-1:0] lines;
    logic [`L2_WAYS-1:0]                 way_we;
    cpu_req_t                            cur_req;
    logic [`L2_INDEX_W-1:0]              index;
    logic                                array_we;
    way_t                                way_sel;
    tag_entry_t                          tag_wd;
    logic [`L2_LINE_W-1:0]               line_wd;
    logic                                hit;
    way_t                                hit_way;
    logic [`L2_WORD_W-1:0]               rword;
    logic [`L2_LINE_W-1:0]               merged_line;
    way_t                                victim;
    logic                                plru_update;

    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way
        assign way_we[w] = array_we && (way_sel == way_t'(w));

        l2_sram #(.entry_t(tag_entry_t), .depth(`L2_SETS)) u_tag (
            .clk(clk), .addr(index), .we(way_we[w]), .wdata(tag_wd), .rdata(tags[w])
        );

        l2_sram #(.entry_t(logic [`L2_LINE_W-1:0]), .depth(`L2_SETS)) u_data (
            .clk(clk), .addr(index), .we(way_we[w]), .wdata(line_wd), .rdata(lines[w])
        );
    end

    l2_tag_match u_match (
        .tags(tags), .lines(lines), .addr(cur_req.addr), .wword(cur_req.wdata),
        .hit(hit), .hit_way(hit_way), .rword(rword), .merged_line(merged_line)
    );

    l2_plru u_plru (
        .clk(clk), .rst_n(rst_n), .index(index), .tags(tags),
        .update(plru_update), .hit_way(hit_way), .victim(victim)
    );

    l2_cache_fsm u_fsm (
        .clk(clk), .rst_n(rst_n), .req(req), .req_data(req_data),
        .hit(hit), .hit_way(hit_way), .rword(rword), .merged_line(merged_line),
        .victim(victim), .victim_tag(tags[victim]), .victim_line(lines[victim]),
        .mem_complete(mem_complete), .mem_rdata(mem_rdata),
        .busy(busy), .rdy(rdy), .rdata(rdata), .miss_stall(miss_stall),
        .mem_req(mem_req), .mem_cmd(mem_cmd), .cur_req(cur_req), .index(index),
        .array_we(array_we), .way_sel(way_sel), .tag_wd(tag_wd), .line_wd(line_wd),
        .plru_update(plru_update)
    );

endmodule

// File: l2_cache_fsm.sv
`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module l2_cache_fsm (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req,
    input  l2_cache_pkg::cpu_req_t    req_data,
    input  logic                      hit,
    input  l2_cache_pkg::way_t        hit_way,
    input  logic [`L2_WORD_W-1:0]     rword,
    input  logic [`L2_LINE_W-1:0]     merged_line,
    input  l2_cache_pkg::way_t        victim,
    input  l2_cache_pkg::tag_entry_t  victim_tag,
    input  logic [`L2_LINE_W-1:0]     victim_line,
    input  logic                      mem_complete,
    input  logic [`L2_LINE_W-1:0]     mem_rdata,
    output logic                      busy,
    output logic                      rdy,
    output logic [`L2_WORD_W-1:0]     rdata,
    output logic                      miss_stall,
    output logic                      mem_req,
    output l2_cache_pkg::mem_cmd_t    mem_cmd,
    output l2_cache_pkg::cpu_req_t    cur_req,
    output logic [`L2_INDEX_W-1:0]    index,
    output logic                      array_we,
    output l2_cache_pkg::way_t        way_sel,
    output l2_cache_pkg::tag_entry_t  tag_wd,
    output logic [`L2_LINE_W-1:0]     line_wd,
    output logic                      plru_update
);

    import l2_cache_pkg::*;

    l2_state_t state;
    l2_state_t state_nxt;
    cpu_req_t  req_q;        // request being served
    way_t      victim_q;     // way chosen at miss time
    logic      miss_q;
    logic      dirty_evict;

    assign cur_req     = req_q;
    assign busy        = (state != st_idle);
    assign dirty_evict = victim_tag.valid && victim_tag.dirty;

    // arrays see the new index while idle so the read lands in lookup
    assign index = (state == st_idle) ? req_data.addr.index : req_q.addr.index;

    // raised as soon as lookup misses, dropped once the retry hits
    assign miss_stall = miss_q || ((state == st_lookup) && !hit);

    always_comb begin
        state_nxt    = state;
        array_we     = 1'b0;
        plru_update  = 1'b0;
        way_sel      = hit_way;
        line_wd      = merged_line;
        tag_wd.valid = 1'b1;
        tag_wd.dirty = 1'b1;
        tag_wd.tag   = req_q.addr.tag;
        case (state)
            st_idle: begin
                if (req) state_nxt = st_lookup;
            end
            st_lookup: begin
                if (hit) begin
                    state_nxt   = st_idle;
                    plru_update = 1'b1;
                    array_we    = req_q.write;   // store merges into the line
                end else if (dirty_evict) begin
                    state_nxt = st_writeback;
                end else begin
                    state_nxt = st_fill;
                end
            end
            st_writeback: begin
                if (mem_complete) state_nxt = st_fill;
            end
            st_fill: begin
                if (mem_complete) begin
                    state_nxt    = st_lookup;    // retry as a hit
                    array_we     = 1'b1;
                    way_sel      = victim_q;
                    tag_wd.dirty = 1'b0;
                    line_wd      = mem_rdata;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            rdy     <= 1'b0;
            mem_req <= 1'b0;
            miss_q  <= 1'b0;
        end else begin
            state   <= state_nxt;
            rdy     <= (state == st_lookup) && hit;
            mem_req <= ((state == st_lookup) && !hit)
                    || ((state == st_writeback) && mem_complete);
            if (state == st_lookup) miss_q <= !hit;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == st_idle) && req) begin
            req_q <= req_data;
        end
        if ((state == st_lookup) && hit) begin
            rdata <= rword;
        end
        if ((state == st_lookup) && !hit) begin
            victim_q <= victim;
            if (dirty_evict) begin
                mem_cmd.write     <= 1'b1;   // victim goes out first
                mem_cmd.line_addr <= {victim_tag.tag, req_q.addr.index};
                mem_cmd.wline     <= victim_line;
            end else begin
                mem_cmd.write     <= 1'b0;
                mem_cmd.line_addr <= {req_q.addr.tag, req_q.addr.index};
                mem_cmd.wline     <= '0;
            end
        end
        if ((state == st_writeback) && mem_complete) begin
            mem_cmd.write     <= 1'b0;       // now fetch the requested line
            mem_cmd.line_addr <= {req_q.addr.tag, req_q.addr.index};
            mem_cmd.wline     <= '0;
        end
    end

endmodule

// File: l2_plru.sv
`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module l2_plru (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [`L2_INDEX_W-1:0]                  index,
    input  l2_cache_pkg::tag_entry_t [`L2_WAYS-1:0] tags,
    input  logic                                    update,
    input  l2_cache_pkg::way_t                      hit_way,
    output l2_cache_pkg::way_t                      victim
);

    import l2_cache_pkg::*;

    // bit 0 root, bit 1 left pair, bit 2 right pair
    logic [2:0] tree [`L2_SETS];
    logic [2:0] cur;

    assign cur = tree[index];

    always_comb begin
        if (!tags[0].valid) begin
            victim = 2'd0;
        end else if (!tags[1].valid) begin
            victim = 2'd1;
        end else if (!tags[2].valid) begin
            victim = 2'd2;
        end else if (!tags[3].valid) begin
            victim = 2'd3;
        end else if (!cur[0]) begin
            victim = cur[1] ? 2'd1 : 2'd0;   // left pair
        end else begin
            victim = cur[2] ? 2'd3 : 2'd2;   // right pair
        end
    end

    // point the tree away from the way just used
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                tree[s] <= 3'b000;
            end
        end else if (update) begin
            case (hit_way)
                2'd0: tree[index] <= {cur[2], 1'b1, 1'b1};
                2'd1: tree[index] <= {cur[2], 1'b0, 1'b1};
                2'd2: tree[index] <= {1'b1, cur[1], 1'b0};
                default: tree[index] <= {1'b0, cur[1], 1'b0};
            endcase
        end
    end

endmodule

// File: l2_tag_match.sv
`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module l2_tag_match (
    input  l2_cache_pkg::tag_entry_t [`L2_WAYS-1:0] tags,
    input  logic [`L2_WAYS-1:0][`L2_LINE_W-1:0]     lines,
    input  l2_cache_pkg::l2_addr_t                  addr,
    input  logic [`L2_WORD_W-1:0]                   wword,
    output logic                                    hit,
    output l2_cache_pkg::way_t                      hit_way,
    output logic [`L2_WORD_W-1:0]                   rword,
    output logic [`L2_LINE_W-1:0]                   merged_line
);

    import l2_cache_pkg::*;

    localparam int n_words = 1 << `L2_OFFSET_W;

    logic [n_words-1:0][`L2_WORD_W-1:0] hit_words;
    logic [n_words-1:0][`L2_WORD_W-1:0] new_words;

    // scan from the top so the lowest matching way wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--) begin
            if (tags[w].valid && (tags[w].tag == addr.tag)) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign hit_words = lines[hit_way]; // way 0 when nothing matches

    assign rword = hit_words[addr.offset];

    // store path, replace one word and keep the rest of the line
    always_comb begin
        new_words              = hit_words;
        new_words[addr.offset] = wword;
    end

    assign merged_line = new_words;

endmodule

// File: l2_sram.sv
`timescale 1ns/1ps
`include "l2_cache_defs.svh"

module l2_sram #(
    parameter type entry_t = logic [`L2_LINE_W-1:0],
    parameter int  depth   = `L2_SETS
) (
    input  logic                     clk,
    input  logic [$clog2(depth)-1:0] addr,
    input  logic                     we,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [depth];

    // write-first, so a refilled line is seen on the next read
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
            rdata     <= wdata;
        end else begin
            rdata     <= mem[addr];
        end
    end

endmodule

// File: l2_cache_pkg.sv
`include "l2_cache_defs.svh"

package l2_cache_pkg;

    typedef logic [1:0] way_t;

    // cpu address as seen by the cache
    typedef struct packed {
        logic [`L2_TAG_W-1:0]    tag;
        logic [`L2_INDEX_W-1:0]  index;
        logic [`L2_OFFSET_W-1:0] offset;
        logic [`L2_ADDR_W-`L2_TAG_W-`L2_INDEX_W-`L2_OFFSET_W-1:0] byte_off; // ignored
    } l2_addr_t;

    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`L2_TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic                  write;   // 1 = store, 0 = load
        l2_addr_t              addr;
        logic [`L2_WORD_W-1:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic                      write;     // 1 = writeback, 0 = line fetch
        logic [`L2_MEM_ADDR_W-1:0] line_addr;
        logic [`L2_LINE_W-1:0]     wline;
    } mem_cmd_t;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_fill
    } l2_state_t;

endpackage

// File: l2_cache_defs.svh
`ifndef L2_CACHE_DEFS_SVH
`define L2_CACHE_DEFS_SVH

// request address layout, tag | index | offset | byte
`define L2_ADDR_W      32
`define L2_TAG_W       17
`define L2_INDEX_W     9
`define L2_OFFSET_W    2

// data path widths
`define L2_WORD_W      128   // one cpu word
`define L2_LINE_W      512   // four words per line

// organisation
`define L2_WAYS        4
`define L2_SETS        512

// memory side addresses whole lines
`define L2_MEM_ADDR_W  26

`endif
